// File: Makefile
TOP = digitizer_channel_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation reported failures"; \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
verilog/dgz_pkg.sv
verilog/signal_expansioner.sv
verilog/hit_detector.sv
verilog/add_header_footer.sv
verilog/digitizer_channel.sv
dv/digitizer_channel_asserts.sv
dv/digitizer_channel_tb.sv

// File: dv/digitizer_channel_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module digitizer_channel_asserts (
  input wire logic                           CLK,
  input wire logic                           RESETN,
  input wire logic [dgz_pkg::data_width-1:0] DOUT,
  input wire logic                           ADDING_VALID,
  input wire logic                           TRIGGERED
);

  logic is_header;

  assign is_header = (DOUT[127:64] == '1) && (DOUT[63:56] == dgz_pkg::header_id);

  a_valid_low_in_reset: assert property (@(posedge CLK) $past(!RESETN) |-> !ADDING_VALID)
    else $error("ADDING_VALID high during reset");

  a_no_double_header: assert property (@(posedge CLK) disable iff (!RESETN)
    is_header |=> !is_header)
    else $error("header id on DOUT in two consecutive cycles");

  // TRIGGERED trails the hitting DIN word by one cycle and the window trails it by one more
  a_window_start: assert property (@(posedge CLK) disable iff (!RESETN)
    $rose(ADDING_VALID) |-> ($past(TRIGGERED) && !$past(TRIGGERED, 2)))
    else $error("ADDING_VALID did not rise two cycles after the triggering word");

endmodule

bind digitizer_channel digitizer_channel_asserts asserts_i (
  .CLK          (CLK),
  .RESETN       (RESETN),
  .DOUT         (DOUT),
  .ADDING_VALID (ADDING_VALID),
  .TRIGGERED    (triggered)
);

`default_nettype wire

// File: dv/digitizer_channel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module digitizer_channel_tb;

  localparam int reset_cycles   = 16;
  localparam int warm_cycles    = 80;
  localparam int pass_cycles    = 50;
  localparam int pulse_cycles   = 200;
  localparam int pulse_runs     = 5;
  localparam int random_cycles  = 2000;
  localparam int total_cycles   = (reset_cycles + pass_cycles)
                                  + pulse_runs * (reset_cycles + warm_cycles + pulse_cycles)
                                  + (reset_cycles + warm_cycles + random_cycles);
  localparam int quiet_level    = 200;
  localparam int pulse_level    = 3000;
  localparam logic [dgz_pkg::adc_width-1:0] run_threshold = 12'd100;

  logic                            CLK;
  logic                            RESETN;
  logic [dgz_pkg::data_width-1:0]  DIN;
  logic                            DIN_VALID;
  logic [dgz_pkg::adc_width-1:0]   THRESHOLD;
  logic [dgz_pkg::delay_width-1:0] DELAY;
  logic [dgz_pkg::data_width-1:0]  DOUT;
  logic                            ADDING_VALID;

  integer seed;
  string  cur_test;
  int     checks;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  int     headers_seen;
  int     footers_seen;
  int     av_cycles;

  // Channel model state
  logic [dgz_pkg::adc_width-1:0]        m_baseline;
  logic                                 m_trig;
  logic                                 m_dv;
  logic                                 m_trig_d;
  logic                                 m_pre_d;
  logic                                 m_pre_out;
  logic                                 m_long_out;
  logic [dgz_pkg::delay_width-1:0]      m_pre_rem;
  logic [dgz_pkg::delay_width-1:0]      m_long_rem;
  logic [dgz_pkg::delay_width-1:0]      m_pre_len;
  logic [dgz_pkg::delay_width-1:0]      m_long_len;
  logic [dgz_pkg::time_stamp_width-1:0] m_ts;
  logic [dgz_pkg::data_width-1:0]       m_data;
  logic [dgz_pkg::data_width-1:0]       m_dout;
  logic [dgz_pkg::adc_width-1:0]        m_bwh;
  logic [dgz_pkg::adc_width:0]          m_twh;
  dgz_pkg::frame_sel_e                  m_sel;

  digitizer_channel #(
    .CHANNEL_ID(5)
  ) dut_i (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .DIN          (DIN),
    .DIN_VALID    (DIN_VALID),
    .THRESHOLD    (THRESHOLD),
    .DELAY        (DELAY),
    .DOUT         (DOUT),
    .ADDING_VALID (ADDING_VALID)
  );

  always #5 CLK = ~CLK;

  initial begin
    #((total_cycles + 200) * 10);
    $display("Timeout: the run did not finish within the expected number of cycles");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [dgz_pkg::data_width-1:0] header_word(
    input logic [dgz_pkg::time_stamp_width-1:0] ts
  );
    return {{dgz_pkg::header_footer_width{1'b1}}, dgz_pkg::header_id, 4'd5,
            ts[47:24], {dgz_pkg::header_pad_width{1'b0}}};
  endfunction

  function automatic logic [dgz_pkg::data_width-1:0] footer_word(
    input logic [dgz_pkg::adc_width-1:0]        bwh,
    input logic [dgz_pkg::adc_width:0]          twh,
    input logic [dgz_pkg::time_stamp_width-1:0] ts
  );
    return {4'hf, bwh, 3'b111, twh, ts[23:0], dgz_pkg::footer_id,
            {dgz_pkg::header_footer_width{1'b1}}};
  endfunction

  // Every lane near one level with the ones fill on top
  function automatic logic [dgz_pkg::data_width-1:0] lane_word(input int level);
    logic [dgz_pkg::data_width-1:0] w;
    int i;
    for (i = 0; i < dgz_pkg::lane_count; i++) begin
      w[i*dgz_pkg::lane_width +: dgz_pkg::lane_width] = {4'hf, 12'(level + ($random(seed) & 15))};
    end
    return w;
  endfunction

  task automatic stretch_step(input logic in, input logic [dgz_pkg::delay_width-1:0] len,
                              inout logic [dgz_pkg::delay_width-1:0] rem, inout logic out);
    if (in) begin
      rem = len;
      out = 1'b1;
    end else if (rem != '0) begin
      rem = rem - 1'b1;
      out = 1'b1;
    end else begin
      out = 1'b0;
    end
  endtask

  // One rising edge of the channel, using the inputs applied before it
  task automatic model_step();
    logic                          hit;
    logic                          cap;
    logic                          tv;
    logic [dgz_pkg::adc_width:0]   level;
    logic [dgz_pkg::adc_width-1:0] sample;
    logic [dgz_pkg::adc_width-1:0] old_base;
    int                            diff;
    int                            step;
    int                            i;
    level = {1'b0, m_baseline} + {1'b0, THRESHOLD};
    hit = 1'b0;
    for (i = 0; i < dgz_pkg::lane_count; i++) begin
      sample = DIN[i*dgz_pkg::lane_width +: dgz_pkg::adc_width];
      if ({1'b0, sample} > level) begin
        hit = 1'b1;
      end
    end
    hit = hit & DIN_VALID;
    cap = hit & ~m_trig;
    old_base = m_baseline;
    if (!RESETN) begin
      m_baseline = '0;
      m_trig     = 1'b0;
      m_dv       = 1'b0;
      m_trig_d   = 1'b0;
      m_pre_d    = 1'b0;
      m_pre_out  = 1'b0;
      m_long_out = 1'b0;
      m_pre_rem  = '0;
      m_long_rem = '0;
      m_ts       = '0;
      m_dout     = '1;
      m_sel      = dgz_pkg::SEL_DATA;
      m_pre_len  = DELAY;
      m_long_len = DELAY + dgz_pkg::footer_gap;
    end else begin
      tv = m_trig & m_dv;
      if (m_trig && !m_trig_d) begin
        m_sel = dgz_pkg::SEL_HEADER;
      end else if (!m_pre_out && m_pre_d) begin
        m_sel = dgz_pkg::SEL_FOOTER;
      end else begin
        m_sel = dgz_pkg::SEL_DATA;
      end
      case (m_sel)
        dgz_pkg::SEL_HEADER: m_dout = header_word(m_ts);
        dgz_pkg::SEL_FOOTER: m_dout = footer_word(m_bwh, m_twh, m_ts);
        default:             m_dout = m_data;
      endcase
      m_pre_d  = m_pre_out;
      m_trig_d = m_trig;
      stretch_step(tv, m_pre_len, m_pre_rem, m_pre_out);
      stretch_step(tv, m_long_len, m_long_rem, m_long_out);
      if (DIN_VALID && !hit) begin
        diff = int'(DIN[dgz_pkg::adc_width-1:0]) - int'(m_baseline);
        step = diff >>> dgz_pkg::baseline_shift;
        m_baseline = 12'(int'(m_baseline) + step);
      end
      m_trig = hit;
      m_dv   = DIN_VALID;
      m_ts   = m_ts + 48'd1;
    end
    if (cap) begin
      m_bwh = old_base;
      m_twh = level;
    end
    m_data = DIN;
  endtask

  task automatic check_word(input string name, input logic [dgz_pkg::data_width-1:0] exp,
                            input logic [dgz_pkg::data_width-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("Fail %s: expected ADDING_VALID %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      test_errors++;
      $display("Fail %s: expected count %0d, actual %0d", name, exp, act);
    end
  endtask

  // Compare at the falling edge, then apply the next word
  task automatic cycle(input logic [dgz_pkg::data_width-1:0] word, input logic valid);
    @(negedge CLK);
    model_step();
    check_word(cur_test, m_dout, DOUT);
    check_flag(cur_test, m_long_out, ADDING_VALID);
    if (RESETN) begin
      if (DOUT[127:64] == '1 && DOUT[63:56] == dgz_pkg::header_id) begin
        headers_seen++;
      end
      if (DOUT[63:0] == '1 && DOUT[71:64] == dgz_pkg::footer_id) begin
        footers_seen++;
      end
      if (ADDING_VALID) begin
        av_cycles++;
      end
    end
    DIN       = word;
    DIN_VALID = valid;
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    test_errors  = 0;
    headers_seen = 0;
    footers_seen = 0;
    av_cycles    = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "failed",
             test_errors);
  endtask

  task automatic do_reset(input logic [dgz_pkg::delay_width-1:0] delay);
    int i;
    cur_test  = "reset";
    RESETN    = 1'b0;
    DELAY     = delay;
    THRESHOLD = '1;
    for (i = 0; i < reset_cycles; i++) begin
      cycle(lane_word(quiet_level), 1'b0);
    end
    RESETN = 1'b1;
  endtask

  // Let the baseline settle with the trigger disabled
  task automatic warm_up();
    int i;
    THRESHOLD = '1;
    for (i = 0; i < warm_cycles; i++) begin
      cycle(lane_word(quiet_level), 1'b1);
    end
    THRESHOLD = run_threshold;
  endtask

  task automatic pulse_run(input string name, input logic [dgz_pkg::delay_width-1:0] delay,
                           input int plen, input int gap);
    int i;
    do_reset(delay);
    warm_up();
    start_test(name);
    for (i = 0; i < 10; i++) begin
      cycle(lane_word(quiet_level), 1'b1);
    end
    for (i = 0; i < plen; i++) begin
      cycle(lane_word(pulse_level), 1'b1);
    end
    if (gap > 0) begin
      for (i = 0; i < gap; i++) begin
        cycle(lane_word(quiet_level), 1'b1);
      end
      for (i = 0; i < plen; i++) begin
        cycle(lane_word(pulse_level), 1'b1);
      end
    end
    for (i = 0; i < 60; i++) begin
      cycle(lane_word(quiet_level), 1'b1);
    end
    if (gap == 0) begin
      check_count({name, " headers"}, 1, headers_seen);
      check_count({name, " window"}, plen + int'(delay) + 2, av_cycles);
    end else begin
      check_count({name, " window"}, 2 * plen + gap + int'(delay) + 2, av_cycles);
    end
    check_count({name, " footers"}, 1, footers_seen);
    end_test();
  endtask

  initial begin
    int i;
    logic valid;
    CLK          = 1'b0;
    RESETN       = 1'b0;
    DIN          = '1;
    DIN_VALID    = 1'b0;
    THRESHOLD    = '1;
    DELAY        = 5'd3;
    seed         = 32'hffca84b0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    do_reset(5'd3);
    start_test("pass_through");
    for (i = 0; i < pass_cycles; i++) begin
      cycle(lane_word(quiet_level + ($random(seed) & 255)), 1'b1);
    end
    check_count("pass_through headers", 0, headers_seen);
    check_count("pass_through window", 0, av_cycles);
    end_test();

    pulse_run("header", 5'd4, 3, 0);
    pulse_run("footer", 5'd6, 1, 0);
    pulse_run("window_delay_2", 5'd2, 2, 0);
    pulse_run("window_delay_5", 5'd5, 4, 0);
    pulse_run("merged_pulses", 5'd8, 2, 4);

    // Random words with gaps in DIN_VALID and occasional pulses
    do_reset(5'd7);
    warm_up();
    start_test("random_run");
    for (i = 0; i < random_cycles; i++) begin
      valid = (($random(seed) & 7) != 0);
      if (($random(seed) & 63) == 0) begin
        cycle(lane_word(pulse_level), valid);
      end else begin
        cycle(lane_word(quiet_level), valid);
      end
    end
    end_test();

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/add_header_footer.sv
`timescale 1ns/1ns
`default_nettype none

module add_header_footer #(
  parameter int CHANNEL_ID = 0
) (
  input  wire logic                                 CLK,
  input  wire logic                                 RESETN,
  input  wire logic                                 DIN_VALID,
  input  wire logic                                 TRIGGERED,
  input  wire logic [dgz_pkg::delay_width-1:0]      DELAY,
  input  wire logic [dgz_pkg::time_stamp_width-1:0] TIME_STAMP,
  input  wire logic [dgz_pkg::adc_width:0]          THRESHOLD_WHEN_HIT,
  input  wire logic [dgz_pkg::adc_width-1:0]        BASELINE_WHEN_HIT,
  input  wire logic [dgz_pkg::data_width-1:0]       DIN,
  output logic      [dgz_pkg::data_width-1:0]       DOUT,
  output logic                                      ADDING_VALID
);

  logic [dgz_pkg::channel_id_width-1:0]       ch_id;
  logic [dgz_pkg::header_footer_width-1:0]    header;
  logic [dgz_pkg::header_footer_width-1:0]    footer;
  logic [dgz_pkg::lane_width-1:0]             baseline_set;
  logic [dgz_pkg::lane_width-1:0]             threshold_set;
  logic [dgz_pkg::first_time_stamp_width-1:0] first_ts;
  logic [dgz_pkg::later_time_stamp_width-1:0] later_ts;

  logic [dgz_pkg::delay_width-1:0] pre_extend_len;
  logic [dgz_pkg::delay_width-1:0] extend_len;
  logic                            trig_valid;
  logic                            pre_extend_triggered;
  logic                            pre_extend_triggered_d;
  logic                            triggered_d;
  logic                            trig_rise;
  logic                            pre_extend_fall;

  dgz_pkg::frame_sel_e frame_sel;

  assign ch_id    = CHANNEL_ID[dgz_pkg::channel_id_width-1:0];
  assign first_ts = TIME_STAMP[dgz_pkg::time_stamp_width-1 -: dgz_pkg::first_time_stamp_width];
  assign later_ts = TIME_STAMP[dgz_pkg::later_time_stamp_width-1:0];

  // Fields keep the ones fill of a normal lane
  assign baseline_set  = {{dgz_pkg::one_fill_width{1'b1}}, BASELINE_WHEN_HIT};
  assign threshold_set = {{(dgz_pkg::one_fill_width-1){1'b1}}, THRESHOLD_WHEN_HIT};

  assign header = {dgz_pkg::header_id, ch_id, first_ts, {dgz_pkg::header_pad_width{1'b0}}};
  assign footer = {baseline_set, threshold_set, later_ts, dgz_pkg::footer_id};

  // Lengths only change while the channel is held in reset
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pre_extend_len <= DELAY;
      extend_len     <= DELAY + dgz_pkg::footer_gap;
    end
  end

  assign trig_valid = TRIGGERED & DIN_VALID;

  // Short stretch places the footer
  signal_expansioner #(
    .MAX_EXTEND_LEN_WIDTH(dgz_pkg::delay_width)
  ) pre_triggered_expansion (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .EXTEND_LEN (pre_extend_len),
    .SIG_IN     (trig_valid),
    .SIG_OUT    (pre_extend_triggered)
  );

  // Long stretch is the output valid window
  signal_expansioner #(
    .MAX_EXTEND_LEN_WIDTH(dgz_pkg::delay_width)
  ) triggered_expansion (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .EXTEND_LEN (extend_len),
    .SIG_IN     (trig_valid),
    .SIG_OUT    (ADDING_VALID)
  );

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      triggered_d            <= 1'b0;
      pre_extend_triggered_d <= 1'b0;
    end else begin
      triggered_d            <= TRIGGERED;
      pre_extend_triggered_d <= pre_extend_triggered;
    end
  end

  assign trig_rise       = TRIGGERED & ~triggered_d;
  assign pre_extend_fall = ~pre_extend_triggered & pre_extend_triggered_d;

  // Header wins if both edges land together
  always_comb begin
    if (trig_rise) begin
      frame_sel = dgz_pkg::SEL_HEADER;
    end else if (pre_extend_fall) begin
      frame_sel = dgz_pkg::SEL_FOOTER;
    end else begin
      frame_sel = dgz_pkg::SEL_DATA;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      DOUT <= '1;
    end else begin
      case (frame_sel)
        dgz_pkg::SEL_HEADER: DOUT <= {{dgz_pkg::header_footer_width{1'b1}}, header};
        dgz_pkg::SEL_FOOTER: DOUT <= {footer, {dgz_pkg::header_footer_width{1'b1}}};
        default:             DOUT <= DIN;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/dgz_pkg.sv
`default_nettype none

package dgz_pkg;

  // Stream and lane layout
  localparam int data_width     = 128;
  localparam int lane_width     = 16;
  localparam int lane_count     = 8;
  localparam int adc_width      = 12;
  localparam int one_fill_width = 4;

  // Time base
  localparam int time_stamp_width       = 48;
  localparam int first_time_stamp_width = 24;
  localparam int later_time_stamp_width = 24;

  // Header and footer fields
  localparam int header_footer_width = 64;
  localparam int channel_id_width    = 4;
  localparam int head_foot_id_width  = 8;
  localparam int header_pad_width    = header_footer_width - head_foot_id_width
                                       - channel_id_width - first_time_stamp_width;

  localparam logic [head_foot_id_width-1:0] header_id = {head_foot_id_width{1'b1}};
  localparam logic [head_foot_id_width-1:0] footer_id = 8'h0f;

  // Trigger extension
  localparam int delay_width = 5;
  // ADDING_VALID stays up this much longer than the footer stretch
  localparam logic [delay_width-1:0] footer_gap = 2;

  // Baseline follows lane 0 with a 1/8 step
  localparam int baseline_shift = 3;

  // Which word the framer puts on DOUT
  typedef enum logic [1:0] {
    SEL_DATA   = 2'd0,
    SEL_HEADER = 2'd1,
    SEL_FOOTER = 2'd2
  } frame_sel_e;

endpackage

`default_nettype wire

// File: verilog/digitizer_channel.sv
`timescale 1ns/1ns
`default_nettype none

module digitizer_channel #(
  parameter int CHANNEL_ID = 0
) (
  input  wire logic                            CLK,
  input  wire logic                            RESETN,
  input  wire logic [dgz_pkg::data_width-1:0]  DIN,
  input  wire logic                            DIN_VALID,
  input  wire logic [dgz_pkg::adc_width-1:0]   THRESHOLD,
  input  wire logic [dgz_pkg::delay_width-1:0] DELAY,
  output logic      [dgz_pkg::data_width-1:0]  DOUT,
  output logic                                 ADDING_VALID
);

  logic [dgz_pkg::data_width-1:0]       data;
  logic                                 data_valid;
  logic                                 triggered;
  logic [dgz_pkg::time_stamp_width-1:0] time_stamp;
  logic [dgz_pkg::adc_width:0]          threshold_when_hit;
  logic [dgz_pkg::adc_width-1:0]        baseline_when_hit;

  hit_detector hit_detector_i (
    .CLK                (CLK),
    .RESETN             (RESETN),
    .DIN_VALID          (DIN_VALID),
    .DIN                (DIN),
    .THRESHOLD          (THRESHOLD),
    .DATA               (data),
    .DATA_VALID         (data_valid),
    .TRIGGERED          (triggered),
    .TIME_STAMP         (time_stamp),
    .THRESHOLD_WHEN_HIT (threshold_when_hit),
    .BASELINE_WHEN_HIT  (baseline_when_hit)
  );

  add_header_footer #(
    .CHANNEL_ID(CHANNEL_ID)
  ) add_header_footer_i (
    .CLK                (CLK),
    .RESETN             (RESETN),
    .DIN_VALID          (data_valid),
    .TRIGGERED          (triggered),
    .DELAY              (DELAY),
    .TIME_STAMP         (time_stamp),
    .THRESHOLD_WHEN_HIT (threshold_when_hit),
    .BASELINE_WHEN_HIT  (baseline_when_hit),
    .DIN                (data),
    .DOUT               (DOUT),
    .ADDING_VALID       (ADDING_VALID)
  );

endmodule

`default_nettype wire

// File: verilog/hit_detector.sv
`timescale 1ns/1ns
`default_nettype none

module hit_detector (
  input  wire logic                                 CLK,
  input  wire logic                                 RESETN,
  input  wire logic                                 DIN_VALID,
  input  wire logic [dgz_pkg::data_width-1:0]       DIN,
  input  wire logic [dgz_pkg::adc_width-1:0]        THRESHOLD,
  output logic      [dgz_pkg::data_width-1:0]       DATA,
  output logic                                      DATA_VALID,
  output logic                                      TRIGGERED,
  output logic      [dgz_pkg::time_stamp_width-1:0] TIME_STAMP,
  output logic      [dgz_pkg::adc_width:0]          THRESHOLD_WHEN_HIT,
  output logic      [dgz_pkg::adc_width-1:0]        BASELINE_WHEN_HIT
);

  logic [dgz_pkg::adc_width-1:0] lane_sample [dgz_pkg::lane_count];
  logic [dgz_pkg::adc_width-1:0] baseline;
  logic [dgz_pkg::adc_width:0]   thr_level;
  logic                          hit;

  logic signed [dgz_pkg::adc_width:0] base_diff;
  logic signed [dgz_pkg::adc_width:0] base_step;

  // Samples sit in the low twelve bits of every lane
  always_comb begin
    for (int i = 0; i < dgz_pkg::lane_count; i++) begin
      lane_sample[i] = DIN[i*dgz_pkg::lane_width +: dgz_pkg::adc_width];
    end
  end

  assign thr_level = {1'b0, baseline} + {1'b0, THRESHOLD};

  // Any lane strictly above the level fires the trigger
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < dgz_pkg::lane_count; i++) begin
      if ({1'b0, lane_sample[i]} > thr_level) begin
        hit = 1'b1;
      end
    end
    hit = hit & DIN_VALID;
  end

  assign base_diff = $signed({1'b0, lane_sample[0]}) - $signed({1'b0, baseline});
  assign base_step = base_diff >>> dgz_pkg::baseline_shift;

  // Baseline moves only on quiet valid words
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      baseline <= '0;
    end else if (DIN_VALID && !hit) begin
      baseline <= baseline + base_step[dgz_pkg::adc_width-1:0];
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      TRIGGERED  <= 1'b0;
      DATA_VALID <= 1'b0;
    end else begin
      TRIGGERED  <= hit;
      DATA_VALID <= DIN_VALID;
    end
  end

  // Data lines up with TRIGGERED
  always_ff @(posedge CLK) begin
    DATA <= DIN;
  end

  // Hold the levels in use when TRIGGERED goes high
  always_ff @(posedge CLK) begin
    if (hit && !TRIGGERED) begin
      BASELINE_WHEN_HIT  <= baseline;
      THRESHOLD_WHEN_HIT <= thr_level;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      TIME_STAMP <= '0;
    end else begin
      TIME_STAMP <= TIME_STAMP + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/signal_expansioner.sv
`timescale 1ns/1ns
`default_nettype none

module signal_expansioner #(
  parameter int MAX_EXTEND_LEN_WIDTH = 5
) (
  input  wire logic                            CLK,
  input  wire logic                            RESETN,
  input  wire logic [MAX_EXTEND_LEN_WIDTH-1:0] EXTEND_LEN,
  input  wire logic                            SIG_IN,
  output logic                                 SIG_OUT
);

  logic [MAX_EXTEND_LEN_WIDTH-1:0] remain;

  // Counter reloads while the input is high, so close pulses merge
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      remain  <= '0;
      SIG_OUT <= 1'b0;
    end else begin
      if (SIG_IN) begin
        remain  <= EXTEND_LEN;
        SIG_OUT <= 1'b1;
      end else if (remain != '0) begin
        remain  <= remain - 1'b1;
        SIG_OUT <= 1'b1;
      end else begin
        SIG_OUT <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
